// File: vlog.f
+incdir+src
src/mem_pkg.sv
src/mem_req_port.sv
src/mem_arbiter.sv
src/mem_ram_ctrl.sv
src/mem_error_log.sv
src/mem_top.sv
verif/mem_tb_clk.sv
verif/mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory testbench with Verilator, run it, and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mem_tb -o mem_tb_sim

status=0
./obj_dir/mem_tb_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG" || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation passed"

// File: verif/mem_tb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_tb import mem_pkg::*; ();

  localparam int DEPTH    = 1 << `MEM_WORD_ADDR_W;
  localparam int SLOT     = `MEM_ACCESS_CYCLES + 1;  // Grant plus idle cycle
  localparam int MIN_HIT  = 2 + `MEM_ACCESS_CYCLES + 1;
  localparam int MAX_WAIT = MIN_HIT + 2 * SLOT;      // Other port and one refresh ahead
  localparam int TIMEOUT  = 100;

  logic                        sysclk;
  logic                        reset;
  logic                        cpu_start;
  logic [`MEM_ADDR_W-1:0]      cpu_addr;
  logic                        cpu_write;
  logic [`MEM_DATA_W-1:0]      cpu_wdata;
  logic [1:0]                  cpu_diag_par_inv;
  logic                        cpu_busy;
  logic                        cpu_ready;
  logic [`MEM_DATA_W-1:0]      cpu_rdata;
  logic                        cpu_miss;
  logic                        cpu_perr;
  logic                        bus_start;
  logic [`MEM_ADDR_W-1:0]      bus_addr;
  logic                        bus_write;
  logic [`MEM_DATA_W-1:0]      bus_wdata;
  logic [1:0]                  bus_diag_par_inv;
  logic                        bus_busy;
  logic                        bus_ready;
  logic [`MEM_DATA_W-1:0]      bus_rdata;
  logic                        bus_miss;
  logic                        bus_perr;
  logic                        err_clear;
  logic                        err_valid;
  logic [`MEM_WORD_ADDR_W-1:0] err_log_addr;
  logic [1:0]                  err_log_lanes;

  int                     seed = 87242;
  bit                     written [0:DEPTH-1];
  logic [`MEM_DATA_W-1:0] model [0:DEPTH-1];  // Expected RAM contents

  mem_tb_clk clk_i (.sysclk(sysclk), .reset(reset));

  mem_top mem_top_i (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [`MEM_DATA_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [`MEM_WORD_ADDR_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_lanes(input string name, input logic [1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [`MEM_ADDR_W-1:0] hit_addr(input logic [`MEM_WORD_ADDR_W-1:0] word);
    return {`MEM_PAGE_BASE, word};
  endfunction

  // Even parity per byte, flipped where a diagnostic bit is set
  function automatic mem_word_u stored_word(input logic [`MEM_DATA_W-1:0] data,
                                            input logic [1:0] inv);
    mem_word_u w;
    w.lanes.hi.data = data[`MEM_DATA_W-1:`MEM_DATA_W/2];
    w.lanes.lo.data = data[`MEM_DATA_W/2-1:0];
    w.lanes.hi.par  = (^w.lanes.hi.data) ^ inv[1];
    w.lanes.lo.par  = (^w.lanes.lo.data) ^ inv[0];
    return w;
  endfunction

  function automatic logic [1:0] bad_lanes(input mem_word_u w);
    return {w.lanes.hi.par ^ (^w.lanes.hi.data), w.lanes.lo.par ^ (^w.lanes.lo.data)};
  endfunction

  // One request on one port, counted in cycles until ready
  task automatic port_access(input logic use_bus, input logic [`MEM_ADDR_W-1:0] addr,
                             input logic write, input logic [`MEM_DATA_W-1:0] wdata,
                             input logic [1:0] par_inv, output logic [`MEM_DATA_W-1:0] rdata,
                             output logic miss, output logic perr, output int cycles);
    logic done;
    @(negedge sysclk);
    if (use_bus) begin
      {bus_start, bus_addr, bus_write} = {1'b1, addr, write};
      {bus_wdata, bus_diag_par_inv}    = {wdata, par_inv};
    end else begin
      {cpu_start, cpu_addr, cpu_write} = {1'b1, addr, write};
      {cpu_wdata, cpu_diag_par_inv}    = {wdata, par_inv};
    end
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge sysclk);
      cycles++;
      if (use_bus)
        bus_start = 1'b0;
      else
        cpu_start = 1'b0;
      done  = use_bus ? bus_ready : cpu_ready;
      rdata = use_bus ? bus_rdata : cpu_rdata;
      miss  = use_bus ? bus_miss : cpu_miss;
      perr  = use_bus ? bus_perr : cpu_perr;
      // Busy from the cycle after start until ready
      check_flag(use_bus ? "bus_busy" : "cpu_busy", use_bus ? bus_busy : cpu_busy, !done);
      if (!done && cycles >= TIMEOUT) begin
        abort_run($sformatf("%s port gave no ready within %0d cycles",
                            use_bus ? "bus" : "cpu", TIMEOUT));
      end
    end
  endtask

  task automatic write_check(input logic use_bus, input logic [`MEM_WORD_ADDR_W-1:0] word,
                             input logic [`MEM_DATA_W-1:0] data, input logic [1:0] inv,
                             output int cycles);
    logic [`MEM_DATA_W-1:0] rd;
    logic                   m;
    logic                   p;
    port_access(use_bus, hit_addr(word), 1'b1, data, inv, rd, m, p, cycles);
    check_flag(use_bus ? "bus_miss" : "cpu_miss", m, 1'b0);
    check_flag(use_bus ? "bus_perr" : "cpu_perr", p, 1'b0);  // Writes never flag
    model[word]   = data;
    written[word] = 1'b1;
  endtask

  task automatic read_check(input logic use_bus, input logic [`MEM_WORD_ADDR_W-1:0] word,
                            input logic [`MEM_DATA_W-1:0] exp_data, input logic exp_perr,
                            output int cycles);
    logic [`MEM_DATA_W-1:0] rd;
    logic                   m;
    logic                   p;
    port_access(use_bus, hit_addr(word), 1'b0, '0, 2'b00, rd, m, p, cycles);
    check_data(use_bus ? "bus_rdata" : "cpu_rdata", rd, exp_data);
    check_flag(use_bus ? "bus_miss" : "cpu_miss", m, 1'b0);
    check_flag(use_bus ? "bus_perr" : "cpu_perr", p, exp_perr);
  endtask

  task automatic test_cpu_write_read();
    logic [31:0] r;
    int          n;
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      write_check(1'b0, r[`MEM_WORD_ADDR_W-1:0], r[31:16], 2'b00, n);
      read_check(1'b0, r[`MEM_WORD_ADDR_W-1:0], r[31:16], 1'b0, n);
      if (n < MIN_HIT) begin
        abort_run($sformatf("CPU read hit answered after %0d cycles", n));
      end
    end
  endtask

  task automatic test_page_miss();
    logic [31:0]            r;
    logic [`MEM_DATA_W-1:0] rd;
    logic                   m;
    logic                   p;
    int                     n;
    r = $random(seed);
    write_check(1'b0, r[9:0], r[31:16], 2'b00, n);
    port_access(1'b0, {`MEM_PAGE_BASE + 14'd1, r[9:0]}, 1'b1, ~r[31:16], 2'b00, rd, m, p, n);
    if (n != 2) abort_run($sformatf("CPU miss took %0d cycles instead of 2", n));
    check_flag("cpu_miss", m, 1'b1);
    check_data("cpu_rdata", rd, '0);
    port_access(1'b1, {~`MEM_PAGE_BASE, r[9:0]}, 1'b0, '0, 2'b00, rd, m, p, n);
    if (n != 2) abort_run($sformatf("bus miss took %0d cycles instead of 2", n));
    check_flag("bus_miss", m, 1'b1);
    check_data("bus_rdata", rd, '0);
    read_check(1'b1, r[9:0], r[31:16], 1'b0, n);  // Array untouched by the misses
  endtask

  task automatic test_shared_array();
    logic [31:0] ra;
    logic [31:0] rb;
    int          n;
    ra = $random(seed);
    rb = $random(seed);
    rb[0] = ~ra[0];  // Two distinct words
    write_check(1'b1, ra[9:0], ra[31:16], 2'b00, n);
    write_check(1'b0, rb[9:0], rb[31:16], 2'b00, n);
    read_check(1'b0, ra[9:0], ra[31:16], 1'b0, n);
    read_check(1'b1, rb[9:0], rb[31:16], 1'b0, n);
  endtask

  task automatic test_concurrent();
    logic [31:0]                 rc;
    logic [31:0]                 rb;
    logic [`MEM_WORD_ADDR_W-1:0] wc;
    logic [`MEM_WORD_ADDR_W-1:0] wb;
    int                          nc;
    int                          nb;
    for (int i = 0; i < 100; i++) begin
      rc = $random(seed);
      rb = $random(seed);
      wc = {rc[9:1], 1'b0};  // CPU on even words
      wb = {rb[9:1], 1'b1};  // Bus on odd words
      fork
        if (rc[10] || !written[wc])
          write_check(1'b0, wc, rc[31:16], 2'b00, nc);
        else
          read_check(1'b0, wc, model[wc], 1'b0, nc);
        if (rb[10] || !written[wb])
          write_check(1'b1, wb, rb[31:16], 2'b00, nb);
        else
          read_check(1'b1, wb, model[wb], 1'b0, nb);
      join
      if (nc > MAX_WAIT || nb > MAX_WAIT) begin
        abort_run($sformatf("Access waited too long: CPU %0d, bus %0d, limit %0d cycles",
                            nc, nb, MAX_WAIT));
      end
    end
  endtask

  task automatic test_parity_error();
    logic [31:0] r;
    logic [31:0] r2;
    mem_word_u   bad;
    int          n;
    r  = $random(seed);
    r2 = $random(seed);
    r2[0] = ~r[0];
    bad = stored_word(r[31:16], 2'b01);  // Low lane corrupted
    write_check(1'b0, r[9:0], r[31:16], 2'b01, n);
    read_check(1'b0, r[9:0], r[31:16], |bad_lanes(bad), n);
    check_flag("err_valid", err_valid, 1'b1);
    check_addr("err_log_addr", err_log_addr, r[9:0]);
    check_lanes("err_log_lanes", err_log_lanes, bad_lanes(bad));
    // A later error leaves the first one in place
    write_check(1'b1, r2[9:0], r2[31:16], 2'b10, n);
    read_check(1'b1, r2[9:0], r2[31:16], |bad_lanes(stored_word(r2[31:16], 2'b10)), n);
    check_addr("err_log_addr", err_log_addr, r[9:0]);
    check_lanes("err_log_lanes", err_log_lanes, bad_lanes(bad));
    @(negedge sysclk);
    err_clear = 1'b1;
    @(negedge sysclk);
    err_clear = 1'b0;
    check_flag("err_valid", err_valid, 1'b0);
    write_check(1'b0, r[9:0], r[31:16], 2'b00, n);
    read_check(1'b0, r[9:0], r[31:16], 1'b0, n);
    check_flag("err_valid", err_valid, 1'b0);
  endtask

  initial begin
    int wait_n;
    {cpu_start, cpu_addr, cpu_write, cpu_wdata, cpu_diag_par_inv} = '0;
    {bus_start, bus_addr, bus_write, bus_wdata, bus_diag_par_inv} = '0;
    err_clear = 1'b0;
    @(negedge sysclk);
    wait_n = 0;
    while (reset !== 1'b0) begin
      wait_n++;
      if (wait_n > TIMEOUT) abort_run("Reset was never released");
      @(negedge sysclk);
    end
    test_cpu_write_read();
    test_page_miss();
    test_shared_array();
    test_concurrent();
    test_parity_error();
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: verif/mem_tb_clk.sv
`timescale 1ns/1ps

module mem_tb_clk (
  output logic sysclk,
  output logic reset
);

  initial begin
    sysclk = 1'b0;
    forever #4 sysclk = ~sysclk;  // 8 ns period
  end

  // Held over the first three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge sysclk);
    @(negedge sysclk);
    reset = 1'b0;
  end

endmodule

// File: src/mem_top.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_top import mem_pkg::*; (
  input  logic                        sysclk,
  input  logic                        reset,
  input  logic                        cpu_start,
  input  logic [`MEM_ADDR_W-1:0]      cpu_addr,
  input  logic                        cpu_write,
  input  logic [`MEM_DATA_W-1:0]      cpu_wdata,
  input  logic [1:0]                  cpu_diag_par_inv,
  output logic                        cpu_busy,
  output logic                        cpu_ready,
  output logic [`MEM_DATA_W-1:0]      cpu_rdata,
  output logic                        cpu_miss,
  output logic                        cpu_perr,
  input  logic                        bus_start,
  input  logic [`MEM_ADDR_W-1:0]      bus_addr,
  input  logic                        bus_write,
  input  logic [`MEM_DATA_W-1:0]      bus_wdata,
  input  logic [1:0]                  bus_diag_par_inv,
  output logic                        bus_busy,
  output logic                        bus_ready,
  output logic [`MEM_DATA_W-1:0]      bus_rdata,
  output logic                        bus_miss,
  output logic                        bus_perr,
  input  logic                        err_clear,
  output logic                        err_valid,
  output logic [`MEM_WORD_ADDR_W-1:0] err_log_addr,
  output logic [1:0]                  err_log_lanes
);

  logic                        cpu_lreq;
  logic                        bus_lreq;
  logic                        cpu_gnt;
  logic                        bus_gnt;
  logic [`MEM_WORD_ADDR_W-1:0] cpu_word_addr;
  logic [`MEM_WORD_ADDR_W-1:0] bus_word_addr;
  logic                        cpu_req_write;
  logic                        bus_req_write;
  logic [`MEM_DATA_W-1:0]      cpu_req_wdata;
  logic [`MEM_DATA_W-1:0]      bus_req_wdata;
  logic [1:0]                  cpu_req_par_inv;
  logic [1:0]                  bus_req_par_inv;
  mem_owner_e                  owner;
  logic                        ram_done;
  logic [`MEM_DATA_W-1:0]      ram_rdata;
  logic [1:0]                  ram_err_lanes;
  logic                        err_strobe;
  logic [`MEM_WORD_ADDR_W-1:0] err_addr;

  assign cpu_gnt = (owner == OWN_CPU);
  assign bus_gnt = (owner == OWN_BUS);

  mem_req_port cpu_port_i (
    .sysclk(sysclk), .reset(reset),
    .start(cpu_start), .addr(cpu_addr), .write(cpu_write), .wdata(cpu_wdata),
    .diag_par_inv(cpu_diag_par_inv),
    .busy(cpu_busy), .ready(cpu_ready), .rdata(cpu_rdata),
    .miss(cpu_miss), .perr(cpu_perr),
    .lreq(cpu_lreq), .gnt(cpu_gnt), .ram_done(ram_done),
    .ram_rdata(ram_rdata), .ram_err_lanes(ram_err_lanes),
    .word_addr(cpu_word_addr), .req_write(cpu_req_write),
    .req_wdata(cpu_req_wdata), .req_par_inv(cpu_req_par_inv)
  );

  mem_req_port bus_port_i (
    .sysclk(sysclk), .reset(reset),
    .start(bus_start), .addr(bus_addr), .write(bus_write), .wdata(bus_wdata),
    .diag_par_inv(bus_diag_par_inv),
    .busy(bus_busy), .ready(bus_ready), .rdata(bus_rdata),
    .miss(bus_miss), .perr(bus_perr),
    .lreq(bus_lreq), .gnt(bus_gnt), .ram_done(ram_done),
    .ram_rdata(ram_rdata), .ram_err_lanes(ram_err_lanes),
    .word_addr(bus_word_addr), .req_write(bus_req_write),
    .req_wdata(bus_req_wdata), .req_par_inv(bus_req_par_inv)
  );

  mem_arbiter arbiter_i (
    .sysclk(sysclk), .reset(reset),
    .cpu_lreq(cpu_lreq), .bus_lreq(bus_lreq),
    .ram_done(ram_done), .owner(owner)
  );

  mem_ram_ctrl ram_ctrl_i (
    .sysclk(sysclk), .reset(reset), .owner(owner),
    .cpu_word_addr(cpu_word_addr), .cpu_req_write(cpu_req_write),
    .cpu_req_wdata(cpu_req_wdata), .cpu_req_par_inv(cpu_req_par_inv),
    .bus_word_addr(bus_word_addr), .bus_req_write(bus_req_write),
    .bus_req_wdata(bus_req_wdata), .bus_req_par_inv(bus_req_par_inv),
    .ram_done(ram_done), .ram_rdata(ram_rdata), .ram_err_lanes(ram_err_lanes),
    .err_strobe(err_strobe), .err_addr(err_addr)
  );

  mem_error_log error_log_i (
    .sysclk(sysclk), .reset(reset),
    .err_strobe(err_strobe), .err_addr(err_addr), .err_lanes(ram_err_lanes),
    .err_clear(err_clear), .err_valid(err_valid),
    .err_log_addr(err_log_addr), .err_log_lanes(err_log_lanes)
  );

endmodule

// File: src/mem_error_log.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_error_log (
  input  logic                        sysclk,
  input  logic                        reset,
  input  logic                        err_strobe,
  input  logic [`MEM_WORD_ADDR_W-1:0] err_addr,
  input  logic [1:0]                  err_lanes,
  input  logic                        err_clear,
  output logic                        err_valid,
  output logic [`MEM_WORD_ADDR_W-1:0] err_log_addr,
  output logic [1:0]                  err_log_lanes
);

  logic capture;

  // New error taken when empty or when cleared in the same cycle
  assign capture = err_strobe && (!err_valid || err_clear);

  always_ff @(posedge sysclk) begin
    if (reset) begin
      err_valid <= 1'b0;
    end else if (capture) begin
      err_valid <= 1'b1;
    end else if (err_clear) begin
      err_valid <= 1'b0;
    end
  end

  // First error held until software clears it
  always_ff @(posedge sysclk) begin
    if (capture) begin
      err_log_addr  <= err_addr;
      err_log_lanes <= err_lanes;
    end
  end

endmodule

// File: src/mem_ram_ctrl.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ram_ctrl import mem_pkg::*; (
  input  logic                        sysclk,
  input  logic                        reset,
  input  mem_owner_e                  owner,
  input  logic [`MEM_WORD_ADDR_W-1:0] cpu_word_addr,
  input  logic                        cpu_req_write,
  input  logic [`MEM_DATA_W-1:0]      cpu_req_wdata,
  input  logic [1:0]                  cpu_req_par_inv,
  input  logic [`MEM_WORD_ADDR_W-1:0] bus_word_addr,
  input  logic                        bus_req_write,
  input  logic [`MEM_DATA_W-1:0]      bus_req_wdata,
  input  logic [1:0]                  bus_req_par_inv,
  output logic                        ram_done,
  output logic [`MEM_DATA_W-1:0]      ram_rdata,
  output logic [1:0]                  ram_err_lanes,
  output logic                        err_strobe,
  output logic [`MEM_WORD_ADDR_W-1:0] err_addr
);

  localparam int CNT_W = $clog2(`MEM_ACCESS_CYCLES);
  localparam int DEPTH = 1 << `MEM_WORD_ADDR_W;
  localparam int HALF  = `MEM_DATA_W / 2;

  logic [CNT_W-1:0]            cnt;      // Cycle within the slot
  logic                        first;
  logic                        is_access;
  logic                        rd_flag;  // Current slot is a read
  logic [`MEM_WORD_ADDR_W-1:0] sel_addr;
  logic                        sel_write;
  logic [`MEM_DATA_W-1:0]      sel_wdata;
  logic [1:0]                  sel_par_inv;
  logic [1:0]                  chk_lanes;
  mem_word_u                   wr_word;
  mem_word_u                   rd_word;

  logic [$bits(mem_word_u)-1:0] mem_array [0:DEPTH-1];

  assign is_access = (owner == OWN_CPU) || (owner == OWN_BUS);
  assign first     = (owner != OWN_NONE) && (cnt == '0);
  assign ram_done  = (owner != OWN_NONE) && (cnt == CNT_W'(`MEM_ACCESS_CYCLES - 1));

  // Granted port's captured request
  always_comb begin
    case (owner)
      OWN_BUS: begin
        sel_addr    = bus_word_addr;
        sel_write   = bus_req_write;
        sel_wdata   = bus_req_wdata;
        sel_par_inv = bus_req_par_inv;
      end
      default: begin
        sel_addr    = cpu_word_addr;
        sel_write   = cpu_req_write;
        sel_wdata   = cpu_req_wdata;
        sel_par_inv = cpu_req_par_inv;
      end
    endcase
  end

  // Even parity per lane, optionally inverted for diagnostics
  always_comb begin
    wr_word.lanes.hi.data = sel_wdata[`MEM_DATA_W-1:HALF];
    wr_word.lanes.lo.data = sel_wdata[HALF-1:0];
    wr_word.lanes.hi.par  = (^sel_wdata[`MEM_DATA_W-1:HALF]) ^ sel_par_inv[1];
    wr_word.lanes.lo.par  = (^sel_wdata[HALF-1:0]) ^ sel_par_inv[0];
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      cnt     <= '0;
      rd_flag <= 1'b0;
    end else begin
      if (owner == OWN_NONE || ram_done) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      if (first) begin
        rd_flag <= is_access && !sel_write;  // Refresh slot never reads
      end
    end
  end

  // Array port, used once at the start of each slot
  always_ff @(posedge sysclk) begin
    if (first && is_access) begin
      if (sel_write) begin
        mem_array[sel_addr] <= wr_word.raw;
      end else begin
        rd_word.raw <= mem_array[sel_addr];
      end
    end
  end

  assign chk_lanes[1] = rd_word.lanes.hi.par ^ (^rd_word.lanes.hi.data);
  assign chk_lanes[0] = rd_word.lanes.lo.par ^ (^rd_word.lanes.lo.data);

  assign ram_rdata     = rd_flag ? {rd_word.lanes.hi.data, rd_word.lanes.lo.data} : '0;
  assign ram_err_lanes = rd_flag ? chk_lanes : 2'b00;
  assign err_strobe    = ram_done && (|ram_err_lanes);
  assign err_addr      = sel_addr;

  // Ports must hold their request for the whole slot
  a_req_stable: assert property (
    @(posedge sysclk) disable iff (reset)
    (is_access && cnt != '0) |-> ($stable(sel_addr) && $stable(sel_write))
  );

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_arbiter import mem_pkg::*; (
  input  logic       sysclk,
  input  logic       reset,
  input  logic       cpu_lreq,
  input  logic       bus_lreq,
  input  logic       ram_done,
  output mem_owner_e owner
);

  localparam int RCNT_W = $clog2(`MEM_REFRESH_INTERVAL);

  logic [RCNT_W-1:0] ref_cnt;
  logic              ref_tick;
  logic              ref_pend;
  logic              last_bus;   // Bus was served last
  mem_owner_e        next_owner;

  assign ref_tick = (ref_cnt == RCNT_W'(`MEM_REFRESH_INTERVAL - 1));

  // Refresh first, then the requester not served last
  always_comb begin
    if (ref_pend) begin
      next_owner = OWN_REF;
    end else if (cpu_lreq && bus_lreq) begin
      next_owner = last_bus ? OWN_CPU : OWN_BUS;
    end else if (cpu_lreq) begin
      next_owner = OWN_CPU;
    end else if (bus_lreq) begin
      next_owner = OWN_BUS;
    end else begin
      next_owner = OWN_NONE;
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      ref_cnt  <= '0;
      ref_pend <= 1'b0;
      owner    <= OWN_NONE;
      last_bus <= 1'b0;
    end else begin
      ref_cnt  <= ref_tick ? '0 : ref_cnt + 1'b1;
      ref_pend <= ref_tick || (ref_pend && owner != OWN_NONE);  // Cleared when granted
      if (owner == OWN_NONE) begin
        owner <= next_owner;
        if (next_owner == OWN_CPU) last_bus <= 1'b0;
        if (next_owner == OWN_BUS) last_bus <= 1'b1;
      end else if (ram_done) begin
        owner <= OWN_NONE;  // Idle cycle between grants
      end
    end
  end

  a_owner_via_none: assert property (
    @(posedge sysclk) disable iff (reset)
    (owner != $past(owner) && $past(owner) != OWN_NONE) |-> owner == OWN_NONE
  );

  // RAM controller answers in a fixed slot after each grant
  a_done_timing: assert property (
    @(posedge sysclk) disable iff (reset)
    ($past(owner) == OWN_NONE && owner != OWN_NONE)
      |-> ##(`MEM_ACCESS_CYCLES - 1) ram_done
  );

endmodule

// File: src/mem_req_port.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_req_port (
  input  logic                        sysclk,
  input  logic                        reset,
  input  logic                        start,
  input  logic [`MEM_ADDR_W-1:0]      addr,
  input  logic                        write,
  input  logic [`MEM_DATA_W-1:0]      wdata,
  input  logic [1:0]                  diag_par_inv,
  output logic                        busy,
  output logic                        ready,
  output logic [`MEM_DATA_W-1:0]      rdata,
  output logic                        miss,
  output logic                        perr,
  output logic                        lreq,
  input  logic                        gnt,
  input  logic                        ram_done,
  input  logic [`MEM_DATA_W-1:0]      ram_rdata,
  input  logic [1:0]                  ram_err_lanes,
  output logic [`MEM_WORD_ADDR_W-1:0] word_addr,
  output logic                        req_write,
  output logic [`MEM_DATA_W-1:0]      req_wdata,
  output logic [1:0]                  req_par_inv
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_DECODE = 2'd1;
  localparam logic [1:0] ST_WAIT   = 2'd2;
  localparam logic [1:0] ST_DONE   = 2'd3;

  logic [1:0]             state;
  logic [`MEM_ADDR_W-1:0] addr_q;
  logic                   hit;
  logic                   accept;
  logic                   served;

  assign busy   = (state == ST_DECODE) || (state == ST_WAIT);
  assign ready  = (state == ST_DONE);
  assign lreq   = (state == ST_WAIT);
  assign accept = start && !busy;           // Legal in idle or in the ready cycle
  assign served = lreq && gnt && ram_done;  // Our access finished

  // Page window compare on the captured address
  assign hit       = (addr_q[`MEM_ADDR_W-1:`MEM_WORD_ADDR_W] == `MEM_PAGE_BASE);
  assign word_addr = addr_q[`MEM_WORD_ADDR_W-1:0];

  always_ff @(posedge sysclk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: state <= accept ? ST_DECODE : ST_IDLE;
        ST_DECODE:        state <= hit ? ST_WAIT : ST_DONE;
        ST_WAIT: begin
          if (served) begin
            state <= ST_DONE;
          end
        end
        default:          state <= ST_IDLE;
      endcase
    end
  end

  // Request capture, held until the next accept
  always_ff @(posedge sysclk) begin
    if (accept) begin
      addr_q      <= addr;
      req_write   <= write;
      req_wdata   <= wdata;
      req_par_inv <= diag_par_inv;
    end
  end

  // Reply registers, valid while ready is high
  always_ff @(posedge sysclk) begin
    if (state == ST_DECODE && !hit) begin
      rdata <= '0;
      miss  <= 1'b1;
      perr  <= 1'b0;
    end else if (served) begin
      rdata <= ram_rdata;
      miss  <= 1'b0;
      perr  <= |ram_err_lanes;  // Any lane flagged
    end
  end

  // Requester must wait for ready before the next start
  a_no_start_while_busy: assert property (
    @(posedge sysclk) disable iff (reset) start |-> !busy
  );

endmodule

// File: src/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

  // Source currently holding the RAM
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_CPU  = 2'd1,
    OWN_BUS  = 2'd2,
    OWN_REF  = 2'd3
  } mem_owner_e;

  // One byte lane as stored, parity above the byte
  typedef struct packed {
    logic                      par;
    logic [`MEM_DATA_W/2-1:0]  data;
  } mem_lane_s;

  // Stored word, seen by the array as raw bits and by the parity logic as lanes
  typedef union packed {
    logic [2*$bits(mem_lane_s)-1:0] raw;
    struct packed {
      mem_lane_s hi;
      mem_lane_s lo;
    } lanes;
  } mem_word_u;

endpackage

// File: src/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus and data widths
`define MEM_ADDR_W 24
`define MEM_DATA_W 16

// 1024 words inside the module
`define MEM_WORD_ADDR_W 10

// Address bits 23:10 of a hit
`define MEM_PAGE_BASE 14'h0021

// Grant to done, in cycles
`define MEM_ACCESS_CYCLES 4

// Cycles between refresh requests
`define MEM_REFRESH_INTERVAL 64

`endif
